//--- riscv_fpu_tests.txt
# name instr rs1_data rs2_data x_data | expected: illegal rd_is_int rd_wdata fflags
# hex fields, fflags is {NV,DZ,OF,UF,NX}, result fields unused on illegal lines
feq_zeros        a020a2d3 00000000 80000000 00000000 0 1 00000001 00
feq_snan         a020a2d3 7f800001 3f800000 00000000 0 1 00000000 10
flt_qnan         a02092d3 7fc00000 3f800000 00000000 0 1 00000000 10
fle_zeros        a02082d3 80000000 00000000 00000000 0 1 00000001 00
fmin_nan         282082d3 7fc00000 40000000 00000000 0 0 40000000 00
fmax_both_nan    282092d3 7fc00000 7f800001 00000000 0 0 7fc00000 10
cvtw_rne_2p5     c00082d3 40200000 00000000 00000000 0 1 00000002 01
cvtw_rtz_m3p5    c00092d3 c0600000 00000000 00000000 0 1 fffffffd 01
cvtw_sat_3e9     c00082d3 4f32d05e 00000000 00000000 0 1 7fffffff 10
cvtwu_exact_3e9  c01082d3 4f32d05e 00000000 00000000 0 1 b2d05e00 00
cvtwu_nan        c01082d3 7fc00000 00000000 00000000 0 1 ffffffff 10
cvtwu_neg        c01082d3 bf800000 00000000 00000000 0 1 00000000 10
ill_cvt_rm7      c000f2d3 3f800000 00000000 00000000 1 0 00000000 00
cvtsw_rne_up     d00082d3 00000000 00000000 01000003 0 0 4b800002 01
cvtswu_rtz_max   d01092d3 00000000 00000000 ffffffff 0 0 4f7fffff 01
cvtsw_min        d00082d3 00000000 00000000 80000000 0 0 cf000000 00
fsgnjx_neg_neg   2020a2d3 bf800000 c0000000 00000000 0 0 3f800000 00
ill_fsgnj_f3     2020b2d3 3f800000 3f800000 00000000 1 0 00000000 00
fmv_x_w          e00082d3 12345678 00000000 00000000 0 1 12345678 00
fmv_w_x          f00082d3 00000000 00000000 deadbeef 0 0 deadbeef 00
fclass_neg_inf   e00092d3 ff800000 00000000 00000000 0 1 00000001 00
fclass_neg_norm  e00092d3 bf800000 00000000 00000000 0 1 00000002 00
fclass_neg_sub   e00092d3 80000001 00000000 00000000 0 1 00000004 00
fclass_neg_zero  e00092d3 80000000 00000000 00000000 0 1 00000008 00
fclass_pos_zero  e00092d3 00000000 00000000 00000000 0 1 00000010 00
fclass_pos_sub   e00092d3 00000001 00000000 00000000 0 1 00000020 00
fclass_pos_norm  e00092d3 3f800000 00000000 00000000 0 1 00000040 00
fclass_pos_inf   e00092d3 7f800000 00000000 00000000 0 1 00000080 00
fclass_snan      e00092d3 7f800001 00000000 00000000 0 1 00000100 00
fclass_qnan      e00092d3 7fc00000 00000000 00000000 0 1 00000200 00

//--- riscv_fpu.f
fpu_pkg.sv
fpu_op_if.sv
fpu_decode.sv
fpu_compare.sv
fpu_convert.sv
fpu_sign_class.sv
fpu_result.sv
riscv_fpu.sv
riscv_fpu_assert.sv
tb_riscv_fpu.sv

//--- Bender.yml
package:
  name: riscv_fpu

sources:
  - fpu_pkg.sv
  - fpu_op_if.sv
  - fpu_decode.sv
  - fpu_compare.sv
  - fpu_convert.sv
  - fpu_sign_class.sv
  - fpu_result.sv
  - riscv_fpu.sv
  - target: test
    files:
      - riscv_fpu_assert.sv
      - tb_riscv_fpu.sv

//--- tb_riscv_fpu.sv
`timescale 1ns/1ps

module tb_riscv_fpu;

    logic        clk;
    logic        rst_l;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] x_data;
    logic        rd_we;
    logic        illegal;
    logic [4:0]  rd;
    logic        rd_is_int;
    logic [31:0] rd_wdata;
    logic [4:0]  fflags;

    string       q_name[$];
    logic [31:0] q_instr[$];
    logic        q_ill[$];
    logic        q_int[$];
    logic [31:0] q_data[$];
    logic [4:0]  q_flags[$];
    int          issue_q[$];

    int neg_cycle = 0;
    int checks = 0;
    int value_errors = 0;
    int other_errors = 0;

    riscv_fpu DUT (
        .clk         (clk),
        .rst_l       (rst_l),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .x_data      (x_data),
        .rd_we       (rd_we),
        .illegal     (illegal),
        .rd          (rd),
        .rd_is_int   (rd_is_int),
        .rd_wdata    (rd_wdata),
        .fflags      (fflags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic drive_instr(input string name, input logic [31:0] ins,
                               input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] x, input logic ill, input logic is_int,
                               input logic [31:0] data, input logic [4:0] flags);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        rs1_data    <= a;
        rs2_data    <= b;
        x_data      <= x;
        q_name.push_back(name);
        q_instr.push_back(ins);
        q_ill.push_back(ill);
        q_int.push_back(is_int);
        q_data.push_back(data);
        q_flags.push_back(flags);
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("** Error %s %s: expected %h actual %h", name, field, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_result();
        string       name;
        logic [31:0] ins;
        logic        e_ill;
        logic        e_int;
        logic [31:0] e_data;
        logic [4:0]  e_flags;
        int          issued;
        if (q_name.size() == 0 || issue_q.size() == 0) begin
            $display("result pulse at cycle %0d with no instruction in flight", neg_cycle);
            other_errors++;
            return;
        end
        name    = q_name.pop_front();
        ins     = q_instr.pop_front();
        e_ill   = q_ill.pop_front();
        e_int   = q_int.pop_front();
        e_data  = q_data.pop_front();
        e_flags = q_flags.pop_front();
        issued  = issue_q.pop_front();
        compare_field(name, "latency", 32'd2, neg_cycle - issued);
        compare_field(name, "illegal", e_ill, illegal);
        compare_field(name, "rd_we", !e_ill, rd_we);
        if (!e_ill) begin
            compare_field(name, "rd", ins[11:7], rd); // rd field of the instruction
            compare_field(name, "rd_is_int", e_int, rd_is_int);
            compare_field(name, "rd_wdata", e_data, rd_wdata);
            compare_field(name, "fflags", e_flags, fflags);
        end
    endtask

    always @(negedge clk) begin
        if (rst_l) begin
            neg_cycle++;
            if (instr_valid)
                issue_q.push_back(neg_cycle);
            if (rd_we || illegal)
                check_result();
        end
    end

    initial begin
        int          fd;
        int          n;
        int          vectors;
        int          wait_cycles;
        int          assert_errors;
        string       line;
        string       name;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] x;
        logic [31:0] e_ill;
        logic [31:0] e_int;
        logic [31:0] e_data;
        logic [31:0] e_flags;
        logic [31:0] rng;
        logic [4:0]  rdn;
        rst_l       = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'd0;
        rs1_data    = 32'd0;
        rs2_data    = 32'd0;
        x_data      = 32'd0;
        vectors     = 0;
        rng         = 32'ha62c;
        #1 rst_l = 1'b0;
        repeat (16) @(posedge clk);
        rst_l <= 1'b1;

        fd = $fopen("riscv_fpu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open riscv_fpu_tests.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, ins, a, b, x,
                            e_ill, e_int, e_data, e_flags);
                if (n == 9) begin
                    drive_instr(name, ins, a, b, x, e_ill[0], e_int[0], e_data, e_flags[4:0]);
                    vectors++;
                end
            end
            $fclose(fd);
        end
        if (vectors == 0) begin
            $display("no test vectors were read from the data file");
            other_errors++;
        end

        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            a   = rng;
            rng = xorshift(rng);
            b   = rng;
            rdn = rng[4:0];
            ins = {fpu_pkg::F7_FSGNJ, 5'd2, 5'd1, fpu_pkg::F3_FSGNJX, rdn, fpu_pkg::OPC_OP_FP};
            drive_instr("rand_fsgnjx", ins, a, b, 32'd0, 1'b0, 1'b0,
                        {a[31] ^ b[31], a[30:0]}, 5'd0);
            ins = {fpu_pkg::F7_FMV_X_W, 5'd0, 5'd1, fpu_pkg::F3_FMV, ~rdn, fpu_pkg::OPC_OP_FP};
            drive_instr("rand_fmv_x_w", ins, b, a, 32'd0, 1'b0, 1'b1, b, 5'd0);
        end
        @(posedge clk);
        instr_valid <= 1'b0;

        wait_cycles = 0;
        while (q_name.size() != 0 && wait_cycles < 50) begin // pipeline is two deep
            @(posedge clk);
            wait_cycles++;
        end
        if (q_name.size() != 0) begin
            $display("timed out with %0d results still outstanding", q_name.size());
            other_errors++;
        end
        repeat (2) @(posedge clk);

        assert_errors = DUT.u_assert.fail_count;
        $display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
                 checks, value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- riscv_fpu_assert.sv
`timescale 1ns/1ps

module riscv_fpu_assert (
    input logic clk,
    input logic rst_l,
    input logic instr_valid,
    input logic rd_we,
    input logic illegal
);

    int fail_count = 0;

    a_excl: assert property (@(posedge clk) !(rd_we && illegal))
        else begin
            $error("rd_we and illegal high in the same cycle");
            fail_count++;
        end

    a_reset: assert property (@(posedge clk) !rst_l |-> (!rd_we && !illegal))
        else begin
            $error("writeback strobe high during reset");
            fail_count++;
        end

    // decode stage then result stage
    a_resp: assert property (@(posedge clk) disable iff (!rst_l)
                             instr_valid |-> ##2 (rd_we ^ illegal))
        else begin
            $error("instruction not answered by exactly one strobe two cycles later");
            fail_count++;
        end

endmodule

bind riscv_fpu riscv_fpu_assert u_assert (
    .clk         (clk),
    .rst_l       (rst_l),
    .instr_valid (instr_valid),
    .rd_we       (rd_we),
    .illegal     (illegal)
);

//--- riscv_fpu.sv
`timescale 1ns/1ps

module riscv_fpu (
    input  logic        clk,
    input  logic        rst_l,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] x_data,
    output logic        rd_we,
    output logic        illegal,
    output logic [4:0]  rd,
    output logic        rd_is_int,
    output logic [31:0] rd_wdata,
    output logic [4:0]  fflags
);

    logic [31:0] cmp_result;
    logic [4:0]  cmp_flags;
    logic [31:0] cvt_result;
    logic [4:0]  cvt_flags;
    logic [31:0] sgn_result;

    fpu_op_if op_if ();

    fpu_decode u_decode (
        .clk         (clk),
        .rst_l       (rst_l),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .x_data      (x_data),
        .op          (op_if.decode)
    );

    fpu_compare u_compare (
        .op     (op_if.exec),
        .result (cmp_result),
        .flags  (cmp_flags)
    );

    fpu_convert u_convert (
        .op     (op_if.exec),
        .result (cvt_result),
        .flags  (cvt_flags)
    );

    fpu_sign_class u_sign_class (
        .op     (op_if.exec),
        .result (sgn_result)
    );

    fpu_result u_result (
        .clk        (clk),
        .rst_l      (rst_l),
        .op         (op_if.result),
        .cmp_result (cmp_result),
        .cmp_flags  (cmp_flags),
        .cvt_result (cvt_result),
        .cvt_flags  (cvt_flags),
        .sgn_result (sgn_result),
        .rd_we      (rd_we),
        .illegal    (illegal),
        .rd         (rd),
        .rd_is_int  (rd_is_int),
        .rd_wdata   (rd_wdata),
        .fflags     (fflags)
    );

endmodule

//--- fpu_result.sv
`timescale 1ns/1ps

module fpu_result (
    input  logic        clk,
    input  logic        rst_l,
    fpu_op_if.result    op,
    input  logic [31:0] cmp_result,
    input  logic [4:0]  cmp_flags,
    input  logic [31:0] cvt_result,
    input  logic [4:0]  cvt_flags,
    input  logic [31:0] sgn_result,
    output logic        rd_we,
    output logic        illegal,
    output logic [4:0]  rd,
    output logic        rd_is_int,
    output logic [31:0] rd_wdata,
    output logic [4:0]  fflags
);

    logic [31:0] sel_result;
    logic [4:0]  sel_flags;

    always_comb begin
        case (op.unit)
            fpu_pkg::UNIT_CMP: begin
                sel_result = cmp_result;
                sel_flags  = cmp_flags;
            end
            fpu_pkg::UNIT_CVT: begin
                sel_result = cvt_result;
                sel_flags  = cvt_flags;
            end
            fpu_pkg::UNIT_SGN: begin
                sel_result = sgn_result;
                sel_flags  = 5'd0; // sign ops raise nothing
            end
            default: begin
                sel_result = 32'd0;
                sel_flags  = 5'd0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            rd_we    <= 1'b0;
            illegal  <= 1'b0;
            rd_wdata <= 32'd0;
            fflags   <= 5'd0;
        end else begin
            rd_we   <= op.valid && (op.unit != fpu_pkg::UNIT_NONE);
            illegal <= op.valid && (op.unit == fpu_pkg::UNIT_NONE);
            if (op.valid) begin
                rd_wdata <= sel_result;
                fflags   <= sel_flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            rd        <= op.rd;
            rd_is_int <= op.to_int;
        end
    end

endmodule

//--- fpu_sign_class.sv
`timescale 1ns/1ps

module fpu_sign_class (
    fpu_op_if.exec      op,
    output logic [31:0] result
);

    logic       exp_ones;
    logic       exp_zero;
    logic       man_zero;
    logic [9:0] class_mask;

    assign exp_ones = (op.rs1.f.exp == 8'hff);
    assign exp_zero = (op.rs1.f.exp == 8'h00);
    assign man_zero = (op.rs1.f.man == 23'd0);

    always_comb begin
        class_mask    = 10'd0;
        class_mask[0] = op.rs1.f.sign && exp_ones && man_zero; // -inf
        class_mask[1] = op.rs1.f.sign && !exp_ones && !exp_zero;
        class_mask[2] = op.rs1.f.sign && exp_zero && !man_zero;
        class_mask[3] = op.rs1.f.sign && exp_zero && man_zero;
        class_mask[4] = !op.rs1.f.sign && exp_zero && man_zero;
        class_mask[5] = !op.rs1.f.sign && exp_zero && !man_zero;
        class_mask[6] = !op.rs1.f.sign && !exp_ones && !exp_zero;
        class_mask[7] = !op.rs1.f.sign && exp_ones && man_zero; // +inf
        class_mask[8] = exp_ones && !man_zero && !op.rs1.f.man[22]; // signaling
        class_mask[9] = exp_ones && op.rs1.f.man[22]; // quiet
    end

    always_comb begin
        result = 32'd0;
        if (op.to_int) begin
            if (op.funct3 == fpu_pkg::F3_FCLASS)
                result = {22'd0, class_mask};
            else
                result = op.rs1.bits; // fmv.x.w
        end else begin
            case (op.funct3)
                fpu_pkg::F3_FSGNJ:    result = {op.rs2.f.sign, op.rs1.bits[30:0]};
                fpu_pkg::F3_FSGNJN:   result = {!op.rs2.f.sign, op.rs1.bits[30:0]};
                fpu_pkg::F3_FSGNJX:   result = {op.rs1.f.sign ^ op.rs2.f.sign, op.rs1.bits[30:0]};
                fpu_pkg::F3_SGN_MVWX: result = op.x_data;
                default:              result = 32'd0;
            endcase
        end
    end

endmodule

//--- fpu_convert.sv
`timescale 1ns/1ps

module fpu_convert (
    fpu_op_if.exec      op,
    output logic [31:0] result,
    output logic [4:0]  flags
);

    logic signed [9:0] exp_unb;
    logic signed [9:0] exp_sh;
    logic [23:0]       man24;
    logic [63:0]       fix;
    logic [31:0]       int_part;
    logic              f_nan;
    logic              f_guard;
    logic              f_sticky;
    logic              f_up;
    logic [32:0]       f_mag;
    logic              f_ovf;
    logic [31:0]       f_res;

    logic              x_neg;
    logic [31:0]       x_mag;
    logic [4:0]        lead;
    logic [31:0]       norm;
    logic              i_guard;
    logic              i_sticky;
    logic              i_up;
    logic [24:0]       i_sum;
    logic [7:0]        i_exp;
    logic [31:0]       i_res;

    assign exp_unb = $signed({2'b00, op.rs1.f.exp}) - 10'sd127;
    assign exp_sh  = exp_unb + 10'sd9;
    assign man24   = {op.rs1.f.exp != 8'd0, op.rs1.f.man};
    assign f_nan   = (op.rs1.f.exp == 8'hff) && (op.rs1.f.man != 23'd0);

    // fixed point, integer part in [63:32], fraction in [31:0]
    always_comb begin
        if (exp_unb > 10'sd31)
            fix = 64'd0; // saturates below
        else if (exp_unb < -10'sd9)
            fix = {63'd0, man24 != 24'd0}; // under one half, sticky only
        else
            fix = {40'd0, man24} << exp_sh[5:0];
    end

    assign int_part = fix[63:32];
    assign f_guard  = fix[31];
    assign f_sticky = |fix[30:0];
    assign f_up     = (op.rm == fpu_pkg::RM_RNE) && f_guard && (f_sticky || int_part[0]);
    assign f_mag    = {1'b0, int_part} + {32'd0, f_up};

    always_comb begin
        if (f_nan || exp_unb > 10'sd31)
            f_ovf = 1'b1;
        else if (op.int_signed)
            f_ovf = op.rs1.f.sign ? (f_mag > 33'h080000000) : (f_mag > 33'h07fffffff);
        else
            f_ovf = op.rs1.f.sign ? (f_mag != 33'd0) : f_mag[32];

        if (f_ovf) begin
            if (op.int_signed)
                f_res = (op.rs1.f.sign && !f_nan) ? 32'h80000000 : 32'h7fffffff;
            else
                f_res = (op.rs1.f.sign && !f_nan) ? 32'h00000000 : 32'hffffffff;
        end else if (op.int_signed && op.rs1.f.sign) begin
            f_res = -f_mag[31:0];
        end else begin
            f_res = f_mag[31:0];
        end
    end

    assign x_neg = op.int_signed && op.x_data[31];
    assign x_mag = x_neg ? -op.x_data : op.x_data;

    always_comb begin
        lead = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (x_mag[i])
                lead = 5'(i);
        end
    end

    assign norm     = x_mag << (5'd31 - lead); // leading one to bit 31
    assign i_guard  = norm[7];
    assign i_sticky = |norm[6:0];
    assign i_up     = (op.rm == fpu_pkg::RM_RNE) && i_guard && (i_sticky || norm[8]);
    assign i_sum    = {1'b0, norm[31:8]} + {24'd0, i_up};
    assign i_exp    = 8'd127 + {3'd0, lead} + {7'd0, i_sum[24]};
    assign i_res    = (x_mag == 32'd0) ? 32'd0 :
                      {x_neg, i_exp, i_sum[24] ? i_sum[23:1] : i_sum[22:0]};

    always_comb begin
        flags = 5'd0;
        if (op.to_int) begin
            result                  = f_res;
            flags[fpu_pkg::FLAG_NV] = f_ovf;
            flags[fpu_pkg::FLAG_NX] = !f_ovf && (f_guard || f_sticky);
        end else begin
            result                  = i_res;
            flags[fpu_pkg::FLAG_NX] = i_guard || i_sticky;
        end
    end

endmodule

//--- fpu_compare.sv
`timescale 1ns/1ps

module fpu_compare (
    fpu_op_if.exec      op,
    output logic [31:0] result,
    output logic [4:0]  flags
);

    logic a_nan;
    logic b_nan;
    logic a_snan;
    logic b_snan;
    logic any_nan;
    logic any_snan;
    logic both_zero;
    logic lt_tot;
    logic lt_ord;
    logic eq;

    assign a_nan  = (op.rs1.f.exp == 8'hff) && (op.rs1.f.man != 23'd0);
    assign b_nan  = (op.rs2.f.exp == 8'hff) && (op.rs2.f.man != 23'd0);
    assign a_snan = a_nan && !op.rs1.f.man[22];
    assign b_snan = b_nan && !op.rs2.f.man[22];
    assign any_nan  = a_nan || b_nan;
    assign any_snan = a_snan || b_snan;

    assign both_zero = (op.rs1.bits[30:0] == 31'd0) && (op.rs2.bits[30:0] == 31'd0);

    // sign-magnitude order, -0 below +0
    assign lt_tot = (op.rs1.f.sign != op.rs2.f.sign) ? op.rs1.f.sign :
                    op.rs1.f.sign ? (op.rs1.bits[30:0] > op.rs2.bits[30:0]) :
                                    (op.rs1.bits[30:0] < op.rs2.bits[30:0]);
    assign lt_ord = lt_tot && !both_zero; // zeros compare equal
    assign eq     = !any_nan && ((op.rs1.bits == op.rs2.bits) || both_zero);

    always_comb begin
        result = 32'd0;
        flags  = 5'd0;
        if (op.to_int) begin
            case (op.funct3)
                fpu_pkg::F3_FEQ: begin
                    result[0]              = eq;
                    flags[fpu_pkg::FLAG_NV] = any_snan; // quiet compare
                end
                fpu_pkg::F3_FLT: begin
                    result[0]              = !any_nan && lt_ord;
                    flags[fpu_pkg::FLAG_NV] = any_nan;
                end
                fpu_pkg::F3_FLE: begin
                    result[0]              = !any_nan && (lt_ord || eq);
                    flags[fpu_pkg::FLAG_NV] = any_nan;
                end
                default: result = 32'd0;
            endcase
        end else begin
            flags[fpu_pkg::FLAG_NV] = any_snan;
            if (a_nan && b_nan)
                result = fpu_pkg::CANON_NAN;
            else if (a_nan)
                result = op.rs2.bits;
            else if (b_nan)
                result = op.rs1.bits;
            else if (op.funct3 == fpu_pkg::F3_FMAX)
                result = lt_tot ? op.rs2.bits : op.rs1.bits;
            else
                result = lt_tot ? op.rs1.bits : op.rs2.bits;
        end
    end

endmodule

//--- fpu_decode.sv
`timescale 1ns/1ps

module fpu_decode (
    input  logic           clk,
    input  logic           rst_l,
    input  logic           instr_valid,
    input  logic [31:0]    instr,
    input  fpu_pkg::fp32_t rs1_data,
    input  fpu_pkg::fp32_t rs2_data,
    input  logic [31:0]    x_data,
    fpu_op_if.decode       op
);

    logic [6:0]         opcode;
    logic [4:0]         rd;
    logic [2:0]         funct3;
    logic [4:0]         funct5;
    logic [6:0]         funct7;
    logic               rm_ok;
    fpu_pkg::fpu_unit_t unit_d;
    logic               to_int_d;
    logic               int_signed_d;
    logic [2:0]         funct3_d;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12]; // also rm
    assign funct5 = instr[24:20]; // rs2 slot
    assign funct7 = instr[31:25];

    assign rm_ok = (funct3 == fpu_pkg::RM_RNE) || (funct3 == fpu_pkg::RM_RTZ);

    always_comb begin
        unit_d       = fpu_pkg::UNIT_NONE;
        to_int_d     = 1'b0;
        int_signed_d = 1'b0;
        funct3_d     = funct3;
        if (opcode == fpu_pkg::OPC_OP_FP) begin
            case (funct7)
                fpu_pkg::F7_FSGNJ: begin
                    if (funct3 == fpu_pkg::F3_FSGNJ || funct3 == fpu_pkg::F3_FSGNJN ||
                        funct3 == fpu_pkg::F3_FSGNJX)
                        unit_d = fpu_pkg::UNIT_SGN;
                end
                fpu_pkg::F7_FMINMAX: begin
                    if (funct3 == fpu_pkg::F3_FMIN || funct3 == fpu_pkg::F3_FMAX)
                        unit_d = fpu_pkg::UNIT_CMP;
                end
                fpu_pkg::F7_FCMP: begin
                    to_int_d = 1'b1;
                    if (funct3 == fpu_pkg::F3_FLE || funct3 == fpu_pkg::F3_FLT ||
                        funct3 == fpu_pkg::F3_FEQ)
                        unit_d = fpu_pkg::UNIT_CMP;
                end
                fpu_pkg::F7_FCVT_W_S, fpu_pkg::F7_FCVT_S_W: begin
                    to_int_d     = (funct7 == fpu_pkg::F7_FCVT_W_S);
                    int_signed_d = (funct5 == fpu_pkg::F5_W);
                    if ((funct5 == fpu_pkg::F5_W || funct5 == fpu_pkg::F5_WU) && rm_ok)
                        unit_d = fpu_pkg::UNIT_CVT;
                end
                fpu_pkg::F7_FMV_X_W: begin
                    to_int_d = 1'b1;
                    if (funct5 == 5'd0 &&
                        (funct3 == fpu_pkg::F3_FMV || funct3 == fpu_pkg::F3_FCLASS))
                        unit_d = fpu_pkg::UNIT_SGN;
                end
                fpu_pkg::F7_FMV_W_X: begin
                    funct3_d = fpu_pkg::F3_SGN_MVWX;
                    if (funct5 == 5'd0 && funct3 == fpu_pkg::F3_FMV)
                        unit_d = fpu_pkg::UNIT_SGN;
                end
                default: unit_d = fpu_pkg::UNIT_NONE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            op.valid      <= 1'b0;
            op.unit       <= fpu_pkg::UNIT_NONE;
            op.to_int     <= 1'b0;
            op.int_signed <= 1'b0;
        end else begin
            op.valid <= instr_valid; // one-cycle strobe
            if (instr_valid) begin
                op.unit       <= unit_d;
                op.to_int     <= to_int_d;
                op.int_signed <= int_signed_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            op.funct3 <= funct3_d;
            op.rm     <= funct3;
            op.rs1    <= rs1_data;
            op.rs2    <= rs2_data;
            op.x_data <= x_data;
            op.rd     <= rd;
        end
    end

endmodule

//--- fpu_op_if.sv
`timescale 1ns/1ps

interface fpu_op_if;

    logic               valid;
    fpu_pkg::fpu_unit_t unit;
    logic [2:0]         funct3;
    logic [2:0]         rm;
    logic               int_signed;
    logic               to_int;     // writes the integer register file
    fpu_pkg::fp32_t     rs1;
    fpu_pkg::fp32_t     rs2;
    logic [31:0]        x_data;
    logic [4:0]         rd;

    modport decode (output valid, unit, funct3, rm, int_signed, to_int,
                    output rs1, rs2, x_data, rd);

    modport exec (input funct3, rm, int_signed, to_int, rs1, rs2, x_data);

    modport result (input valid, unit, to_int, rd);

endinterface

//--- fpu_pkg.sv
package fpu_pkg;

    localparam logic [6:0] OPC_OP_FP = 7'b1010011;

    localparam logic [6:0] F7_FSGNJ    = 7'b0010000;
    localparam logic [6:0] F7_FMINMAX  = 7'b0010100;
    localparam logic [6:0] F7_FCMP     = 7'b1010000;
    localparam logic [6:0] F7_FCVT_W_S = 7'b1100000; // float to int
    localparam logic [6:0] F7_FCVT_S_W = 7'b1101000; // int to float
    localparam logic [6:0] F7_FMV_X_W  = 7'b1110000; // shared with fclass
    localparam logic [6:0] F7_FMV_W_X  = 7'b1111000;

    localparam logic [2:0] F3_FSGNJ  = 3'b000;
    localparam logic [2:0] F3_FSGNJN = 3'b001;
    localparam logic [2:0] F3_FSGNJX = 3'b010;
    localparam logic [2:0] F3_FMIN   = 3'b000;
    localparam logic [2:0] F3_FMAX   = 3'b001;
    localparam logic [2:0] F3_FLE    = 3'b000;
    localparam logic [2:0] F3_FLT    = 3'b001;
    localparam logic [2:0] F3_FEQ    = 3'b010;
    localparam logic [2:0] F3_FMV    = 3'b000;
    localparam logic [2:0] F3_FCLASS = 3'b001;

    // internal sub-op for fmv.w.x, free slot next to the sign injections
    localparam logic [2:0] F3_SGN_MVWX = 3'b011;

    localparam logic [4:0] F5_W  = 5'b00000;
    localparam logic [4:0] F5_WU = 5'b00001;

    localparam logic [2:0] RM_RNE = 3'b000;
    localparam logic [2:0] RM_RTZ = 3'b001;

    // fflags is {NV, DZ, OF, UF, NX}
    localparam int FLAG_NV = 4;
    localparam int FLAG_NX = 0;

    localparam logic [31:0] CANON_NAN = 32'h7fc00000;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] man;
    } fp32_fields_t;

    typedef union packed {
        logic [31:0]  bits;
        fp32_fields_t f;
    } fp32_t;

    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0, // illegal instruction
        UNIT_CMP  = 2'd1,
        UNIT_CVT  = 2'd2,
        UNIT_SGN  = 2'd3
    } fpu_unit_t;

endpackage
